// File: rtl/rv_pkg.sv
/* rv32i base integer definitions only; no csr, trap or compressed encodings */
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // access widths, loads and stores share the low two bits
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

    // arithmetic group, reg and imm forms
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;  // srl or sra by funct7
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_none,
        wb_alu,
        wb_link,
        wb_load
    } wb_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // store and branch split the immediate around rs1/rs2
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } sb_fmt_t;

    typedef union packed {
        r_fmt_t  r;
        sb_fmt_t sb;
    } inst_u;

endpackage

// File: rtl/fetch_unit.sv
/* pc register with reset vector; jalr bit 0 clearing happens in execute */
`timescale 1ns/10ps

module fetch_unit
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            jump_en,
    input  logic [xlen-1:0] jump_target,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] snpc
);

    logic [xlen-1:0] npc;

    assign snpc = pc + 32'd4;
    assign npc  = jump_en ? jump_target : snpc;  // taken branch or jump wins

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= npc;
        end
    end

endmodule

// File: rtl/decode_unit.sv
/* combinational rv32i decode; unknown opcodes decode as a nop with no writeback */
`timescale 1ns/10ps

module decode_unit
    import rv_pkg::*;
(
    input  inst_u                 inst,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    output logic [reg_addr_w-1:0] rd,
    output logic                  reg_we,
    output logic [xlen-1:0]       imm,
    output alu_op_t               alu_op,
    output logic [2:0]            funct3,
    output logic                  is_branch,
    output logic                  is_jal,
    output logic                  is_jalr,
    output logic                  a_is_pc,
    output logic                  a_is_zero,
    output logic                  b_is_imm,
    output logic                  mem_re,
    output logic                  mem_we,
    output wb_sel_t               wb_sel
);

    logic [6:0] opcode;
    logic       funct7_b5;
    alu_op_t    arith_op;

    assign opcode    = inst.r.opcode;
    assign rs1       = inst.r.rs1;
    assign rs2       = inst.r.rs2;
    assign rd        = inst.r.rd;
    assign funct3    = inst.r.funct3;
    assign funct7_b5 = inst.r.funct7[5];

    // sign-extended immediate per format
    always_comb begin
        case (opcode)
            op_store:  imm = {{20{inst.sb.imm_hi[6]}}, inst.sb.imm_hi, inst.sb.imm_lo};
            op_branch: imm = {{20{inst.sb.imm_hi[6]}}, inst.sb.imm_lo[0], inst.sb.imm_hi[5:0],
                              inst.sb.imm_lo[4:1], 1'b0};
            op_lui,
            op_auipc:  imm = {inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'h000};
            op_jal:    imm = {{12{inst.r.funct7[6]}}, inst.r.rs1, inst.r.funct3, inst.r.rs2[0],
                              inst.r.funct7[5:0], inst.r.rs2[4:1], 1'b0};
            default:   imm = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rs2};  // i-type
        endcase
    end

    always_comb begin
        case (funct3)
            f3_add:  arith_op = (opcode == op_reg && funct7_b5) ? alu_sub : alu_add;
            f3_sll:  arith_op = alu_sll;
            f3_slt:  arith_op = alu_slt;
            f3_sltu: arith_op = alu_sltu;
            f3_xor:  arith_op = alu_xor;
            f3_sr:   arith_op = funct7_b5 ? alu_sra : alu_srl;  // srai uses imm[10]
            f3_or:   arith_op = alu_or;
            f3_and:  arith_op = alu_and;
            default: arith_op = alu_add;
        endcase
    end

    always_comb begin
        alu_op    = alu_add;  // address and target sums
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        a_is_pc   = 1'b0;
        a_is_zero = 1'b0;
        b_is_imm  = 1'b1;
        mem_re    = 1'b0;
        mem_we    = 1'b0;
        wb_sel    = wb_none;
        case (opcode)
            op_reg: begin
                b_is_imm = 1'b0;
                alu_op   = arith_op;
                wb_sel   = wb_alu;
            end
            op_imm: begin
                alu_op = arith_op;
                wb_sel = wb_alu;
            end
            op_load: begin
                mem_re = 1'b1;
                wb_sel = wb_load;
            end
            op_store:  mem_we = 1'b1;
            op_branch: begin
                is_branch = 1'b1;
                a_is_pc   = 1'b1;  // alu forms pc + offset
            end
            op_jal: begin
                is_jal  = 1'b1;
                a_is_pc = 1'b1;
                wb_sel  = wb_link;
            end
            op_jalr: begin
                is_jalr = 1'b1;
                wb_sel  = wb_link;
            end
            op_lui: begin
                a_is_zero = 1'b1;
                wb_sel    = wb_alu;
            end
            op_auipc: begin
                a_is_pc = 1'b1;
                wb_sel  = wb_alu;
            end
            default: ;
        endcase
    end

    // x0 writes dropped here
    assign reg_we = (rd != '0) && (wb_sel != wb_none);

endmodule

// File: rtl/reg_file.sv
/* 32 x 32 gpr, two async reads and one sync write; new data visible next cycle */
`timescale 1ns/10ps

module reg_file
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];  // x0 hardwired
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: rtl/execute_unit.sv
/* alu, branch compare and jump target; branch and jal targets come from the alu sum */
`timescale 1ns/10ps

module execute_unit
    import rv_pkg::*;
(
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] snpc,
    input  logic [xlen-1:0] rdata1,
    input  logic [xlen-1:0] rdata2,
    input  logic [xlen-1:0] imm,
    input  alu_op_t         alu_op,
    input  logic [2:0]      funct3,
    input  logic            is_branch,
    input  logic            is_jal,
    input  logic            is_jalr,
    input  logic            a_is_pc,
    input  logic            a_is_zero,
    input  logic            b_is_imm,
    output logic [xlen-1:0] alu_result,
    output logic            jump_en,
    output logic [xlen-1:0] jump_target,
    output logic [xlen-1:0] link
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic            take;

    // lui uses zero, auipc/branch/jal use pc
    assign op_a  = a_is_zero ? '0 : (a_is_pc ? pc : rdata1);
    assign op_b  = b_is_imm ? imm : rdata2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << shamt;
            alu_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> shamt;
            alu_sra:  alu_result = $unsigned($signed(op_a) >>> shamt);
            alu_or:   alu_result = op_a | op_b;
            alu_and:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;  // alu_add
        endcase
    end

    // condition always on register values, not alu operands
    always_comb begin
        case (funct3)
            f3_beq:  take = (rdata1 == rdata2);
            f3_bne:  take = (rdata1 != rdata2);
            f3_blt:  take = ($signed(rdata1) < $signed(rdata2));
            f3_bge:  take = ($signed(rdata1) >= $signed(rdata2));
            f3_bltu: take = (rdata1 < rdata2);
            f3_bgeu: take = (rdata1 >= rdata2);
            default: take = 1'b0;
        endcase
    end

    assign jump_en     = (is_branch && take) || is_jal || is_jalr;
    assign jump_target = is_jalr ? {alu_result[xlen-1:1], 1'b0} : alu_result;
    assign link        = snpc;  // return address for jal/jalr

endmodule

// File: rtl/load_store_unit.sv
/* naturally aligned accesses only; low address bits pick the byte lanes */
`timescale 1ns/10ps

module load_store_unit
    import rv_pkg::*;
(
    input  logic [xlen-1:0] alu_result,
    input  logic [xlen-1:0] rdata2,
    input  logic [2:0]      funct3,
    input  logic            mem_re,
    input  logic            mem_we,
    input  wb_sel_t         wb_sel,
    input  logic [xlen-1:0] link,
    input  logic [xlen-1:0] dmem_rdata,
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    output logic [3:0]      dmem_wmask,
    output logic            dmem_we,
    output logic            dmem_re,
    output logic [xlen-1:0] rd_wdata
);

    logic [1:0]      byte_off;
    logic [xlen-1:0] lane;
    logic [xlen-1:0] load_val;

    assign byte_off  = alu_result[1:0];
    assign dmem_addr = {alu_result[xlen-1:2], 2'b00};
    assign dmem_we   = mem_we;
    assign dmem_re   = mem_re;

    // data replicated into all lanes, mask picks the target
    always_comb begin
        case (funct3)
            f3_sb: begin
                dmem_wdata = {4{rdata2[7:0]}};
                dmem_wmask = 4'b0001 << byte_off;
            end
            f3_sh: begin
                dmem_wdata = {2{rdata2[15:0]}};
                dmem_wmask = 4'b0011 << {byte_off[1], 1'b0};
            end
            f3_sw: begin
                dmem_wdata = rdata2;
                dmem_wmask = 4'b1111;
            end
            default: begin
                dmem_wdata = rdata2;
                dmem_wmask = 4'b0000;  // reserved width writes nothing
            end
        endcase
    end

    assign lane = dmem_rdata >> {byte_off, 3'b000};  // addressed byte down to bit 0

    always_comb begin
        case (funct3)
            f3_lb:   load_val = {{24{lane[7]}}, lane[7:0]};
            f3_lh:   load_val = {{16{lane[15]}}, lane[15:0]};
            f3_lw:   load_val = dmem_rdata;
            f3_lbu:  load_val = {24'h0, lane[7:0]};
            f3_lhu:  load_val = {16'h0, lane[15:0]};
            default: load_val = dmem_rdata;
        endcase
    end

    always_comb begin
        case (wb_sel)
            wb_alu:  rd_wdata = alu_result;
            wb_link: rd_wdata = link;
            wb_load: rd_wdata = load_val;
            default: rd_wdata = '0;  // wb_none, reg_we is low anyway
        endcase
    end

endmodule

// File: rtl/rv_core.sv
/* single-cycle rv32i core; both memories must answer combinationally in the same cycle */
`timescale 1ns/10ps

module rv_core
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    output logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] imem_rdata,
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    output logic [3:0]      dmem_wmask,
    output logic            dmem_we,
    output logic            dmem_re,
    input  logic [xlen-1:0] dmem_rdata
);

    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       snpc;
    logic                  jump_en;
    logic [xlen-1:0]       jump_target;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic                  reg_we;
    logic [xlen-1:0]       imm;
    alu_op_t               alu_op;
    logic [2:0]            funct3;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  a_is_pc;
    logic                  a_is_zero;
    logic                  b_is_imm;
    logic                  mem_re;
    logic                  mem_we;
    wb_sel_t               wb_sel;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       link;
    logic [xlen-1:0]       rd_wdata;

    assign imem_addr = pc;

    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .snpc        (snpc)
    );

    decode_unit u_decode (
        .inst      (imem_rdata),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .reg_we    (reg_we),
        .imm       (imm),
        .alu_op    (alu_op),
        .funct3    (funct3),
        .is_branch (is_branch),
        .is_jal    (is_jal),
        .is_jalr   (is_jalr),
        .a_is_pc   (a_is_pc),
        .a_is_zero (a_is_zero),
        .b_is_imm  (b_is_imm),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .wb_sel    (wb_sel)
    );

    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .we     (reg_we),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (rd_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    execute_unit u_execute (
        .pc          (pc),
        .snpc        (snpc),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .imm         (imm),
        .alu_op      (alu_op),
        .funct3      (funct3),
        .is_branch   (is_branch),
        .is_jal      (is_jal),
        .is_jalr     (is_jalr),
        .a_is_pc     (a_is_pc),
        .a_is_zero   (a_is_zero),
        .b_is_imm    (b_is_imm),
        .alu_result  (alu_result),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .link        (link)
    );

    load_store_unit u_lsu (
        .alu_result (alu_result),
        .rdata2     (rdata2),
        .funct3     (funct3),
        .mem_re     (mem_re),
        .mem_we     (mem_we),
        .wb_sel     (wb_sel),
        .link       (link),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wmask (dmem_wmask),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .rd_wdata   (rd_wdata)
    );

endmodule

// File: tests/rv_core_asserts.sv
/* bound into rv_core; checks hold only outside reset except the reset store rule */
`timescale 1ns/10ps

module rv_core_asserts
    import rv_pkg::*;
(
    input logic            clk,
    input logic            reset,
    input logic [xlen-1:0] imem_addr,
    input logic            dmem_we,
    input logic            dmem_re
);

    int fail_count = 0;

    no_read_and_write: assert property (@(posedge clk) disable iff (reset)
        !(dmem_we && dmem_re))
        else begin
            $error("dmem_we and dmem_re high together");
            fail_count++;
        end

    // fetch is always word aligned
    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_addr[1:0] == 2'b00)
        else begin
            $error("imem_addr not word aligned: %h", imem_addr);
            fail_count++;
        end

    no_store_after_reset: assert property (@(posedge clk) reset |=> !dmem_we)
        else begin
            $error("dmem_we high in the cycle after reset");
            fail_count++;
        end

endmodule

bind rv_core rv_core_asserts u_asserts (.*);

// File: tests/rv_core_tb.sv
/* runs the program in tests/core_cases.txt against both memory models; memories are 256 words,
   indexed by address bits 9:2, so data and code must stay inside that window */
`timescale 1ns/10ps

module rv_core_tb
    import rv_pkg::*;
;

    localparam int mem_words       = 256;
    localparam int cycle_ns        = 4;
    localparam int reset_cycles    = 8;
    localparam int cycles_per_word = 8;

    logic            clk;
    logic            reset;
    logic [xlen-1:0] imem_addr;
    logic [xlen-1:0] imem_rdata;
    logic [xlen-1:0] dmem_addr;
    logic [xlen-1:0] dmem_wdata;
    logic [3:0]      dmem_wmask;
    logic            dmem_we;
    logic            dmem_re;
    logic [xlen-1:0] dmem_rdata;

    logic [31:0] imem [mem_words];
    logic [31:0] dmem [mem_words];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_mask [$];
    int          errors;
    int          n_prog;
    int          store_idx;
    bit          loaded;

    always #(cycle_ns / 2) clk = ~clk;

    // both memories answer within the cycle
    assign imem_rdata = imem[imem_addr[9:2]];
    // inverted word unless dmem_re is up, so a load without it goes wrong
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[9:2]] : ~dmem[dmem_addr[9:2]];

    rv_core u_rv_core (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wmask (dmem_wmask),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    task automatic load_cases();
        int                 fd;
        int                 code;
        byte                kind;
        logic [31:0]        a;
        logic [31:0]        d;
        logic [3:0]         m;
        logic [8*120-1:0]   rest;
        fd = $fopen("tests/core_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/core_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", kind);
                if (code == 1) begin
                    case (kind)
                        "#": code = $fgets(rest, fd);  // comment line
                        "P": begin
                            code = $fscanf(fd, "%h", d);
                            imem[reset_pc[9:2] + n_prog] = d;
                            n_prog++;
                        end
                        "D": begin
                            code = $fscanf(fd, "%h %h", a, d);
                            dmem[a[9:2]] = d;
                        end
                        "S": begin
                            code = $fscanf(fd, "%h %h %h", a, d, m);
                            exp_addr.push_back(a);
                            exp_data.push_back(d);
                            exp_mask.push_back(m);
                        end
                        default: begin
                            $display("unknown line kind in case file");
                            errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_store(input logic [31:0] a, input logic [31:0] word,
                               input logic [3:0] m);
        if (store_idx >= exp_addr.size()) begin
            $display("unexpected extra store to address %h", a);
            errors++;
        end else begin
            if (a !== exp_addr[store_idx]) begin
                $display("[ERROR] dmem_addr got %h expected %h", a, exp_addr[store_idx]);
                errors++;
            end
            if (word !== exp_data[store_idx]) begin
                $display("[ERROR] dmem word at %h got %h expected %h", a, word,
                         exp_data[store_idx]);
                errors++;
            end
            if (m !== exp_mask[store_idx]) begin
                $display("[ERROR] dmem_wmask got %h expected %h", m, exp_mask[store_idx]);
                errors++;
            end
            store_idx++;
        end
    endtask

    // merge under the byte mask, then compare with the next expected store
    always @(posedge clk) begin : store_model
        int          idx;
        logic [31:0] merged;
        if (reset) begin
            if (dmem_we === 1'b1) begin
                $display("store issued during reset to address %h", dmem_addr);
                errors++;
            end
        end else if (dmem_we === 1'b1) begin
            idx    = dmem_addr[9:2];
            merged = dmem[idx];
            for (int b = 0; b < 4; b++) begin
                if (dmem_wmask[b]) merged[8*b +: 8] = dmem_wdata[8*b +: 8];
            end
            dmem[idx] = merged;
            check_store(dmem_addr, merged, dmem_wmask);
        end
    end

    initial begin : watchdog
        wait (loaded);
        #((n_prog * cycles_per_word + reset_cycles) * cycle_ns);
        $display("timeout, core never reached its closing self loop");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : main
        logic [31:0] prev;
        int          same;
        clk    = 1'b0;
        reset  = 1'b1;
        errors = 0;
        n_prog = 0;
        store_idx = 0;
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        load_cases();
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (imem_addr !== reset_pc) begin
            $display("[ERROR] imem_addr got %h expected %h", imem_addr, reset_pc);
            errors++;
        end
        if (n_prog > 0) begin
            prev = imem_addr;
            same = 0;
            while (same < 2) begin  // jal to itself ends the program
                @(negedge clk);
                if (imem_addr === prev) begin
                    same++;
                end else begin
                    same = 0;
                    prev = imem_addr;
                end
            end
        end
        if (store_idx != exp_addr.size()) begin
            $display("only %0d of %0d expected stores were seen", store_idx, exp_addr.size());
            errors++;
        end
        if (u_rv_core.u_asserts.fail_count != 0) begin
            $display("%0d assertion failures in the bound core checks",
                     u_rv_core.u_asserts.fail_count);
            errors += u_rv_core.u_asserts.fail_count;
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tests/core_cases.txt
# P word = program word from 80000000 up; D addr word = initial data
# S addr word mask = expected store, word as merged in memory
D 00001080 80f17f02
D 000010a0 11223344
P 000010b7
P ff900113
P 00500193
P 00310233
P 0040a023
P 40310233
P 0040a223
P 00319233
P 0040a423
P 00312233
P 0040a623
P 00313233
P 0040a823
P 00314233
P 0040aa23
P 00315233
P 0040ac23
P 40315233
P 0040ae23
P 00316233
P 0240a023
P 00317233
P 0240a223
P 40115213
P 0240a423
# branches, fall-through adds a distinct bit to x5
P 00318463
P 00128293
P 00310463
P 00228293
P 00311463
P 00428293
P 00319463
P 00828293
P 00314463
P 01028293
P 0021c463
P 02028293
P 0021d463
P 04028293
P 00315463
P 08028293
P 0021e463
P 10028293
P 00316463
P 20028293
P 0021f463
P 40028293
P 00317463
P 7ff28293
P 0250a623
# jal, auipc and jalr with an odd offset
P 0080036f
P 0220a823
P 0260a823
P 00000397
P 00d38467
P 0220aa23
P 0280aa23
P 0270ac23
# loads from each lane
P 08308483
P 0290ae23
P 0820c483
P 0490a023
P 08108483
P 0490a223
P 0800c483
P 0490a423
P 08209483
P 0490a623
P 0800d483
P 0490a823
P 0800a483
P 0490aa23
# sub-word stores
P 0a2080a3
P 0a3081a3
P 0a208023
P 0a308123
P 0a309023
P 0a209123
# lui, write to x0, final self loop
P abcde537
P 04a0ac23
P 07b00013
P 0400ae23
P 0000006f
S 00001000 fffffffe f
S 00001004 fffffff4 f
S 00001008 000000a0 f
S 0000100c 00000001 f
S 00001010 00000000 f
S 00001014 fffffffc f
S 00001018 07ffffff f
S 0000101c ffffffff f
S 00001020 fffffffd f
S 00001024 00000001 f
S 00001028 fffffffc f
S 0000102c 000006aa f
S 00001030 800000cc f
S 00001034 800000dc f
S 00001038 800000d4 f
S 0000103c ffffff80 f
S 00001040 000000f1 f
S 00001044 0000007f f
S 00001048 00000002 f
S 0000104c ffff80f1 f
S 00001050 00007f02 f
S 00001054 80f17f02 f
S 000010a0 1122f944 2
S 000010a0 0522f944 8
S 000010a0 0522f9f9 1
S 000010a0 0505f9f9 4
S 000010a0 05050005 3
S 000010a0 fff90005 c
S 00001058 abcde000 f
S 0000105c 00000000 f

// File: flist.f
rtl/rv_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/load_store_unit.sv
rtl/rv_core.sv
tests/rv_core_asserts.sv
tests/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - rtl/rv_pkg.sv
      - rtl/fetch_unit.sv
      - rtl/decode_unit.sv
      - rtl/reg_file.sv
      - rtl/execute_unit.sv
      - rtl/load_store_unit.sv
      - rtl/rv_core.sv
  - target: test
    files:
      - tests/rv_core_asserts.sv
      - tests/rv_core_tb.sv
